// ==== project.f ====
+incdir+source
source/fp_add_pkg.sv
source/fp_handshake_ctrl.sv
source/fp_align.sv
source/fp_mant_addsub.sv
source/fp_normalize.sv
source/fp_add_top.sv
bench/tb_clock_gen.sv
bench/fp_add_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the floating-point adder testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -Wno-fatal -f project.f --top-module fp_add_tb \
    -Mdir "$build_dir" -o fp_add_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/fp_add_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "SIMULATION PASSED" "$log_file"; then
    exit 0
fi
exit 1

// ==== bench/fp_add_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_add_macros.svh"

module fp_add_tb;

    localparam int ACK_TIMEOUT = 40;

    logic                 clk;
    logic                 rst;
    logic                 req;
    logic                 ack;
    fp_add_pkg::fp_word_t operand_a;
    fp_add_pkg::fp_word_t operand_b;
    fp_add_pkg::fp_word_t sum;

    integer seed;
    logic   timed_out;
    logic   hold_ok;
    int     rise_latency;
    int     fall_latency;
    int     test_checks;
    int     test_errors;
    int     tests_run;
    int     tests_failed;
    int     total_checks;
    int     total_errors;

    tb_clock_gen clk_gen_i (.clk(clk));

    fp_add_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .ack       (ack),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .sum       (sum)
    );

    // Truncating add with alignment, signed-magnitude add or subtract and normalization
    function automatic fp_add_pkg::fp_word_t model_add(input fp_add_pkg::fp_word_t a,
                                                       input fp_add_pkg::fp_word_t b);
        int          ea;
        int          eb;
        int          e_res;
        logic [24:0] ma;
        logic [24:0] mb;
        logic [24:0] mag;
        logic        sign;
        ea    = int'(a[30:23]);
        eb    = int'(b[30:23]);
        ma    = {2'b01, a[22:0]};
        mb    = {2'b01, b[22:0]};
        e_res = (ea >= eb) ? ea : eb;
        if (ea >= eb) begin
            mb = (ea - eb >= 24) ? 25'd0 : mb >> (ea - eb);
        end else begin
            ma = (eb - ea >= 24) ? 25'd0 : ma >> (eb - ea);
        end
        if (a[`FP_SIGN_BIT] == b[`FP_SIGN_BIT]) begin
            mag  = ma + mb;
            sign = a[`FP_SIGN_BIT];
        end else begin
            mag  = (ma > mb) ? ma - mb : mb - ma;
            sign = (ma > mb) ? a[`FP_SIGN_BIT] : b[`FP_SIGN_BIT];
        end
        if (mag == 25'd0) begin
            return '0;
        end
        if (mag[24]) begin
            mag   = mag >> 1;
            e_res = e_res + 1;
        end
        while (!mag[23]) begin
            mag   = mag << 1;
            e_res = e_res - 1;
        end
        return {sign, e_res[7:0], mag[22:0]};
    endfunction

    task automatic gen_pair(input logic same_sign, output fp_add_pkg::fp_word_t a,
                            output fp_add_pkg::fp_word_t b);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        int          ea;
        int          eb;
        logic [22:0] fb;
        r1 = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        ea = 30 + int'(r1[15:0] % 16'd191);
        // Mostly close exponents for carries and deep cancellation
        eb = (r1[17:16] == 2'd0) ? 30 + int'(r3[31:16] % 16'd191) : ea + int'(r1[20:18]) - 3;
        eb = (eb < 30) ? 30 : ((eb > 220) ? 220 : eb);
        fb = r1[21] ? r3[22:0] : r2[22:0] ^ (r3[22:0] >> r1[26:22]);
        a  = {r1[31], ea[7:0], r2[22:0]};
        b  = {same_sign ? r1[31] : ~r1[31], eb[7:0], fb};
    endtask

    task automatic run_op(input fp_add_pkg::fp_word_t a, input fp_add_pkg::fp_word_t b,
                          input int hold_cycles, output fp_add_pkg::fp_word_t result);
        int waited;
        result = '0;
        @(posedge clk);
        operand_a <= a;
        operand_b <= b;
        req       <= 1'b1;
        @(negedge clk);
        waited = 0;
        while (!ack && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!ack) begin
            $display("ERROR: ack did not rise within %0d cycles of req", ACK_TIMEOUT);
            test_errors++;
            timed_out = 1'b1;
            return;
        end
        // The edge that samples req falls inside the first counted cycle
        rise_latency = waited - 1;
        result       = sum;
        hold_ok      = 1'b1;
        for (int k = 0; k < hold_cycles; k++) begin
            @(negedge clk);
            if (!ack || sum !== result) begin
                hold_ok = 1'b0;
            end
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        waited = 0;
        while (ack && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (ack) begin
            $display("ERROR: ack stayed high for %0d cycles after req dropped", ACK_TIMEOUT);
            test_errors++;
            timed_out = 1'b1;
            return;
        end
        fall_latency = waited - 1;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        test_checks++;
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic add_and_check(input string name, input fp_add_pkg::fp_word_t a,
                                 input fp_add_pkg::fp_word_t b,
                                 input fp_add_pkg::fp_word_t expected);
        fp_add_pkg::fp_word_t result;
        run_op(a, b, 0, result);
        if (!timed_out) begin
            check_value(name, expected, result);
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s finished: %0d checks, %0d errors", name, test_checks, test_errors);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        fp_add_pkg::fp_word_t a;
        fp_add_pkg::fp_word_t b;
        fp_add_pkg::fp_word_t result;
        logic [31:0]          r;
        int                   big_exp;
        int                   gap;
        seed         = 32'hec039b22;
        rst          = 1'b1;
        req          = 1'b0;
        operand_a    = '0;
        operand_b    = '0;
        timed_out    = 1'b0;
        hold_ok      = 1'b0;
        test_checks  = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        total_checks = 0;
        total_errors = 0;
        rise_latency = 0;
        fall_latency = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < 200 && !timed_out; i++) begin
            gen_pair(1'b1, a, b);
            add_and_check("same_sign_add", a, b, model_add(a, b));
        end
        finish_test("same_sign_add");

        for (int i = 0; i < 200 && !timed_out; i++) begin
            gen_pair(1'b0, a, b);
            add_and_check("opposite_sign_sub", a, b, model_add(a, b));
        end
        finish_test("opposite_sign_sub");

        for (int i = 0; i < 20 && !timed_out; i++) begin
            gen_pair(1'b1, a, b);
            add_and_check("exact_cancel", a, {~a[`FP_SIGN_BIT], a[30:0]}, 32'h0);
        end
        finish_test("exact_cancel");

        for (int i = 0; i < 20 && !timed_out; i++) begin
            r = $random(seed);
            gen_pair(r[0], a, b);
            big_exp  = 70 + int'(r[15:8] % 8'd150);
            gap      = 24 + int'(r[21:16] % 6'd40);
            a[30:23] = 8'(big_exp);
            b[30:23] = 8'(big_exp - gap);
            if (r[1]) begin
                add_and_check("large_gap", b, a, a);
            end else begin
                add_and_check("large_gap", a, b, a);
            end
        end
        finish_test("large_gap");

        @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("handshake_protocol ack after reset", 32'd0, 32'(ack));
        check_value("handshake_protocol sum after reset", 32'd0, sum);
        gen_pair(1'b0, a, b);
        run_op(a, b, 10, result);
        if (!timed_out) begin
            check_value("handshake_protocol sum", model_add(a, b), result);
            check_value("handshake_protocol ack rise latency", 32'd4, 32'(rise_latency));
            check_value("handshake_protocol ack fall latency", 32'd1, 32'(fall_latency));
            test_checks++;
            if (!hold_ok) begin
                $display("ERROR: ack dropped or sum changed while req was held high");
                test_errors++;
            end
        end
        finish_test("handshake_protocol");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, total_checks, total_errors);
        if (total_errors == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    localparam realtime HALF_PERIOD = 4ns;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== source/fp_add_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_add_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                req,
    output logic                ack,
    input  fp_add_pkg::fp_word_t operand_a,
    input  fp_add_pkg::fp_word_t operand_b,
    output fp_add_pkg::fp_word_t sum
);

    logic                 align_en;
    logic                 add_en;
    logic                 norm_en;
    fp_add_pkg::fp_mant_t aligned_a;
    fp_add_pkg::fp_mant_t aligned_b;
    fp_add_pkg::fp_exp_t  common_exp;
    logic                 sign_a;
    logic                 sign_b;
    fp_add_pkg::fp_mant_t raw_mant;
    logic                 carry;
    logic                 result_sign;
    fp_add_pkg::fp_exp_t  result_exp;

    fp_handshake_ctrl u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .ack      (ack),
        .align_en (align_en),
        .add_en   (add_en),
        .norm_en  (norm_en)
    );

    fp_align u_align (
        .clk        (clk),
        .rst        (rst),
        .align_en   (align_en),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .aligned_a  (aligned_a),
        .aligned_b  (aligned_b),
        .common_exp (common_exp),
        .sign_a     (sign_a),
        .sign_b     (sign_b)
    );

    fp_mant_addsub u_addsub (
        .clk         (clk),
        .rst         (rst),
        .add_en      (add_en),
        .aligned_a   (aligned_a),
        .aligned_b   (aligned_b),
        .common_exp  (common_exp),
        .sign_a      (sign_a),
        .sign_b      (sign_b),
        .raw_mant    (raw_mant),
        .carry       (carry),
        .result_sign (result_sign),
        .result_exp  (result_exp)
    );

    fp_normalize u_norm (
        .clk         (clk),
        .rst         (rst),
        .norm_en     (norm_en),
        .raw_mant    (raw_mant),
        .carry       (carry),
        .result_sign (result_sign),
        .result_exp  (result_exp),
        .sum         (sum)
    );

endmodule

`default_nettype wire

// ==== source/fp_normalize.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_add_macros.svh"

module fp_normalize (
    input  logic                clk,
    input  logic                rst,
    input  logic                norm_en,
    input  fp_add_pkg::fp_mant_t raw_mant,
    input  logic                carry,
    input  logic                result_sign,
    input  fp_add_pkg::fp_exp_t  result_exp,
    output fp_add_pkg::fp_word_t sum
);

    fp_add_pkg::fp_shift_t lz_count;
    fp_add_pkg::fp_mant_t  shifted_mant;
    fp_add_pkg::fp_frac_t  frac_next;
    fp_add_pkg::fp_exp_t   exp_next;
    fp_add_pkg::fp_word_t  sum_next;
    logic                  found;

    // Leading-zero count is 24 for an all-zero mantissa
    always_comb begin
        lz_count = '0;
        found    = 1'b0;
        for (int i = `FP_MANT_WIDTH - 1; i >= 0; i--) begin
            if (!found) begin
                if (raw_mant[i]) begin
                    found = 1'b1;
                end else begin
                    lz_count = lz_count + 1'b1;
                end
            end
        end
    end

    always_comb begin
        shifted_mant = raw_mant << lz_count;
        if (carry) begin
            // Carry out becomes the new hidden one and the low bit drops
            frac_next = raw_mant[`FP_MANT_WIDTH-1:1];
            exp_next  = result_exp + 1'b1;
        end else begin
            frac_next = shifted_mant[`FP_FRAC_WIDTH-1:0];
            exp_next  = result_exp
                      - {{(`FP_EXP_WIDTH - `FP_LZC_WIDTH){1'b0}}, lz_count};
        end

        // Exact cancellation
        if (!carry && !found) begin
            sum_next = '0;
        end else begin
            sum_next = {result_sign, exp_next, frac_next};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sum <= '0;
        end else if (norm_en) begin
            sum <= sum_next;
        end
    end

endmodule

`default_nettype wire

// ==== source/fp_mant_addsub.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_mant_addsub (
    input  logic                clk,
    input  logic                rst,
    input  logic                add_en,
    input  fp_add_pkg::fp_mant_t aligned_a,
    input  fp_add_pkg::fp_mant_t aligned_b,
    input  fp_add_pkg::fp_exp_t  common_exp,
    input  logic                sign_a,
    input  logic                sign_b,
    output fp_add_pkg::fp_mant_t raw_mant,
    output logic                carry,
    output logic                result_sign,
    output fp_add_pkg::fp_exp_t  result_exp
);

    fp_add_pkg::fp_mant_t mant_next;
    logic                 carry_next;
    logic                 sign_next;

    always_comb begin
        if (sign_a == sign_b) begin
            {carry_next, mant_next} = aligned_a + aligned_b;
            sign_next = sign_a;
        end else begin
            carry_next = 1'b0;
            // Larger magnitude minus smaller with the sign of the larger
            if (aligned_a > aligned_b) begin
                mant_next = aligned_a - aligned_b;
                sign_next = sign_a;
            end else if (aligned_b > aligned_a) begin
                mant_next = aligned_b - aligned_a;
                sign_next = sign_b;
            end else begin
                mant_next = '0;
                sign_next = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            raw_mant    <= '0;
            carry       <= 1'b0;
            result_sign <= 1'b0;
            result_exp  <= '0;
        end else if (add_en) begin
            raw_mant    <= mant_next;
            carry       <= carry_next;
            result_sign <= sign_next;
            result_exp  <= common_exp;
        end
    end

endmodule

`default_nettype wire

// ==== source/fp_align.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_add_macros.svh"

module fp_align (
    input  logic                clk,
    input  logic                rst,
    input  logic                align_en,
    input  fp_add_pkg::fp_word_t operand_a,
    input  fp_add_pkg::fp_word_t operand_b,
    output fp_add_pkg::fp_mant_t aligned_a,
    output fp_add_pkg::fp_mant_t aligned_b,
    output fp_add_pkg::fp_exp_t  common_exp,
    output logic                sign_a,
    output logic                sign_b
);

    fp_add_pkg::fp_exp_t   exp_a;
    fp_add_pkg::fp_exp_t   exp_b;
    fp_add_pkg::fp_mant_t  mant_a;
    fp_add_pkg::fp_mant_t  mant_b;
    fp_add_pkg::fp_exp_t   exp_diff;
    fp_add_pkg::fp_shift_t shift_amt;
    fp_add_pkg::fp_mant_t  small_mant;
    fp_add_pkg::fp_mant_t  small_shifted;
    logic                  a_larger;

    always_comb begin
        exp_a  = operand_a[`FP_SIGN_BIT-1 -: `FP_EXP_WIDTH];
        exp_b  = operand_b[`FP_SIGN_BIT-1 -: `FP_EXP_WIDTH];
        // Hidden one set even for exponent 0
        mant_a = {1'b1, operand_a[`FP_FRAC_WIDTH-1:0]};
        mant_b = {1'b1, operand_b[`FP_FRAC_WIDTH-1:0]};

        a_larger   = (exp_a >= exp_b);
        exp_diff   = a_larger ? (exp_a - exp_b) : (exp_b - exp_a);
        shift_amt  = exp_diff[`FP_LZC_WIDTH-1:0];
        small_mant = a_larger ? mant_b : mant_a;

        // Truncating shift drops everything past the mantissa width
        if (exp_diff >= `FP_MANT_WIDTH) begin
            small_shifted = '0;
        end else begin
            small_shifted = small_mant >> shift_amt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aligned_a  <= '0;
            aligned_b  <= '0;
            common_exp <= '0;
            sign_a     <= 1'b0;
            sign_b     <= 1'b0;
        end else if (align_en) begin
            aligned_a  <= a_larger ? mant_a : small_shifted;
            aligned_b  <= a_larger ? small_shifted : mant_b;
            common_exp <= a_larger ? exp_a : exp_b;
            sign_a     <= operand_a[`FP_SIGN_BIT];
            sign_b     <= operand_b[`FP_SIGN_BIT];
        end
    end

endmodule

`default_nettype wire

// ==== source/fp_handshake_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_handshake_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic req,
    output logic ack,
    output logic align_en,
    output logic add_en,
    output logic norm_en
);

    fp_add_pkg::ctrl_state_t state;
    fp_add_pkg::ctrl_state_t next_state;

    always_comb begin
        next_state = state;
        case (state)
            fp_add_pkg::IDLE: begin
                // Wait for the previous ack to clear first
                if (req && !ack) begin
                    next_state = fp_add_pkg::ALIGN;
                end
            end
            fp_add_pkg::ALIGN: next_state = fp_add_pkg::ADD;
            fp_add_pkg::ADD:   next_state = fp_add_pkg::NORM;
            fp_add_pkg::NORM:  next_state = fp_add_pkg::DONE;
            fp_add_pkg::DONE: begin
                if (!req) begin
                    next_state = fp_add_pkg::IDLE;
                end
            end
            default: next_state = fp_add_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fp_add_pkg::IDLE;
            ack   <= 1'b0;
        end else begin
            state <= next_state;
            // One cycle behind DONE, so ack also lags the req drop by one
            ack   <= (state == fp_add_pkg::DONE);
        end
    end

    assign align_en = (state == fp_add_pkg::ALIGN);
    assign add_en   = (state == fp_add_pkg::ADD);
    assign norm_en  = (state == fp_add_pkg::NORM);

endmodule

`default_nettype wire

// ==== source/fp_add_pkg.sv ====
`default_nettype none

`include "fp_add_macros.svh"

package fp_add_pkg;

    typedef logic [`FP_WIDTH-1:0]      fp_word_t;
    typedef logic [`FP_EXP_WIDTH-1:0]  fp_exp_t;
    typedef logic [`FP_FRAC_WIDTH-1:0] fp_frac_t;
    typedef logic [`FP_MANT_WIDTH-1:0] fp_mant_t;
    typedef logic [`FP_LZC_WIDTH-1:0]  fp_shift_t;

    // One operation walks through every state in turn
    typedef enum logic [2:0] {
        IDLE,
        ALIGN,
        ADD,
        NORM,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== source/fp_add_macros.svh ====
`ifndef FP_ADD_MACROS_SVH
`define FP_ADD_MACROS_SVH

// Single-precision word layout
`define FP_WIDTH        32
`define FP_EXP_WIDTH    8
`define FP_FRAC_WIDTH   23

// Fraction with the hidden one in front
`define FP_MANT_WIDTH   24

`define FP_SIGN_BIT     31

// Enough for a count of 0 to 24
`define FP_LZC_WIDTH    5

`endif
